// ==== flist.f ====
source/cpuIsaPkg.sv
source/cpuDatapathPkg.sv
source/cpuCtrlIf.sv
source/generalRegisters.sv
source/addressRegisters.sv
source/aluUnit.sv
source/controlUnit.sv
source/cpuSystem.sv
testbench/cpuSystemTb.sv

// ==== run.sh ====
#!/bin/bash
set -e

cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -j 0 --top-module cpuSystemTb -f flist.f \
        --Mdir obj_dir -o cpuSystemSim
./obj_dir/cpuSystemSim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
        echo "simulation passed"
else
        echo "simulation failed, see sim.log"
        exit 1
fi

// ==== source/addressRegisters.sv ====
`default_nettype none

module addressRegisters (
        input logic T,
        input logic rstN,
        arfCtrlIf.bank ctrl,
        input cpuDatapathPkg::wordT writeData,
        output cpuDatapathPkg::wordT operand,
        output cpuDatapathPkg::addrT memAddr
);

        cpuDatapathPkg::wordT pc;
        cpuDatapathPkg::wordT ar;

        // a write wins over the increment, the controller never asks for both
        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (ctrl.writePc) begin
                        pc <= writeData;
                end else if (ctrl.incPc) begin
                        pc <= pc + 1'b1;
                end
        end

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        ar <= '0;
                end else if (ctrl.writeAr) begin
                        ar <= writeData;
                end
        end

        always_comb begin
                if (ctrl.readSelAr) begin
                        operand = ar;
                end else begin
                        operand = pc;
                end
        end

        always_comb begin
                if (ctrl.addrSelAr) begin
                        memAddr = ar;                   // LD and ST
                end else begin
                        memAddr = pc;
                end
        end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`default_nettype none

module aluUnit (
        input cpuDatapathPkg::wordT gprA,
        input cpuDatapathPkg::wordT gprB,
        input cpuDatapathPkg::wordT arfOperand,
        input cpuDatapathPkg::byteT memRdData,
        input cpuIsaPkg::immT imm,
        input cpuDatapathPkg::aluFunT aluFun,
        input logic aSrcArf,
        input cpuDatapathPkg::wbSrcT wbSrc,
        output cpuDatapathPkg::wordT result
);

        localparam int wordW = cpuDatapathPkg::wordW;

        cpuDatapathPkg::wordT opA;
        cpuDatapathPkg::wordT aluOut;

        assign opA = aSrcArf ? arfOperand : gprA;      // source 1 may be PC or AR

        always_comb begin
                case (aluFun)
                        cpuDatapathPkg::inc: aluOut = opA + 1'b1;
                        cpuDatapathPkg::dec: aluOut = opA - 1'b1;
                        cpuDatapathPkg::notA: aluOut = ~opA;
                        cpuDatapathPkg::lsl: aluOut = {opA[wordW-2:0], 1'b0};
                        cpuDatapathPkg::lsr: aluOut = {1'b0, opA[wordW-1:1]};
                        cpuDatapathPkg::andAB: aluOut = opA & gprB;
                        cpuDatapathPkg::orrAB: aluOut = opA | gprB;
                        cpuDatapathPkg::add: aluOut = opA + gprB;
                        cpuDatapathPkg::sub: aluOut = opA - gprB;
                        default: aluOut = opA;
                endcase
        end

        // memory byte and address field are zero extended
        always_comb begin
                case (wbSrc)
                        cpuDatapathPkg::wbMem: begin
                                result = {{(wordW - cpuDatapathPkg::byteW){1'b0}}, memRdData};
                        end
                        cpuDatapathPkg::wbImm: begin
                                result = {{(wordW - cpuIsaPkg::immW){1'b0}}, imm};
                        end
                        default: begin
                                result = aluOut;
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`default_nettype none

module controlUnit (
        input logic T,
        input logic rstN,
        input cpuDatapathPkg::byteT memRdData,
        gprCtrlIf.ctrl gpr,
        arfCtrlIf.ctrl arf,
        output cpuDatapathPkg::aluFunT aluFun,
        output logic aSrcArf,
        output cpuDatapathPkg::wbSrcT wbSrc,
        output cpuIsaPkg::immT imm,
        output logic memWr
);

        localparam int byteW = cpuDatapathPkg::byteW;
        localparam int instrW = cpuIsaPkg::instrW;

        cpuDatapathPkg::phaseT phase;
        cpuIsaPkg::instrT ir;
        cpuIsaPkg::opcodeT opcode;
        cpuIsaPkg::regCodeT dst;
        cpuIsaPkg::regCodeT src1;
        cpuIsaPkg::regCodeT src2;
        cpuIsaPkg::gprSelT rsel;
        logic regForm;

        // fixed three cycle rotation, no stalls
        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        phase <= cpuDatapathPkg::fetchLow;
                end else begin
                        case (phase)
                                cpuDatapathPkg::fetchLow: phase <= cpuDatapathPkg::fetchHigh;
                                cpuDatapathPkg::fetchHigh: phase <= cpuDatapathPkg::execute;
                                default: phase <= cpuDatapathPkg::fetchLow;
                        endcase
                end
        end

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        ir <= '0;
                end else if (phase == cpuDatapathPkg::fetchLow) begin
                        ir[byteW-1:0] <= memRdData;
                end else if (phase == cpuDatapathPkg::fetchHigh) begin
                        ir[instrW-1:byteW] <= memRdData;
                end
        end

        assign opcode = cpuIsaPkg::opcodeT'(ir[cpuIsaPkg::opLsb +: cpuIsaPkg::opW]);
        assign dst = ir[cpuIsaPkg::dstLsb +: cpuIsaPkg::regCodeW];
        assign src1 = ir[cpuIsaPkg::src1Lsb +: cpuIsaPkg::regCodeW];
        assign src2 = ir[cpuIsaPkg::src2Lsb +: cpuIsaPkg::regCodeW];
        assign rsel = ir[cpuIsaPkg::rselLsb +: cpuIsaPkg::gprSelW];
        assign imm = ir[cpuIsaPkg::immLsb +: cpuIsaPkg::immW];

        always_comb begin
                // register form defaults, source 1 on port A and source 2 on port B
                gpr.selA = src1[cpuIsaPkg::gprSelW-1:0];
                gpr.selB = src2[cpuIsaPkg::gprSelW-1:0];
                gpr.writeSel = dst[cpuIsaPkg::gprSelW-1:0];
                gpr.write = 1'b0;
                arf.readSelAr = src1 >= cpuIsaPkg::arCodeFirst;
                arf.addrSelAr = 1'b0;
                arf.writeAr = 1'b0;
                arf.writePc = 1'b0;
                arf.incPc = phase != cpuDatapathPkg::execute;    // PC steps over both bytes
                aSrcArf = src1 < cpuIsaPkg::firstGprCode;
                aluFun = cpuDatapathPkg::passA;
                wbSrc = cpuDatapathPkg::wbAlu;
                memWr = 1'b0;
                regForm = 1'b0;

                if (phase == cpuDatapathPkg::execute) begin
                        case (opcode)
                                cpuIsaPkg::opBra: begin
                                        arf.writePc = 1'b1;
                                        wbSrc = cpuDatapathPkg::wbImm;
                                end
                                cpuIsaPkg::opImm: begin
                                        gpr.writeSel = rsel;
                                        gpr.write = 1'b1;
                                        wbSrc = cpuDatapathPkg::wbImm;
                                end
                                cpuIsaPkg::opLd: begin
                                        arf.addrSelAr = 1'b1;
                                        gpr.writeSel = rsel;
                                        gpr.write = 1'b1;
                                        wbSrc = cpuDatapathPkg::wbMem;
                                end
                                cpuIsaPkg::opSt: begin
                                        gpr.selA = rsel;        // port A low byte is the store data
                                        arf.addrSelAr = 1'b1;
                                        memWr = 1'b1;
                                end
                                cpuIsaPkg::opInc: begin
                                        aluFun = cpuDatapathPkg::inc;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opDec: begin
                                        aluFun = cpuDatapathPkg::dec;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opLsl: begin
                                        aluFun = cpuDatapathPkg::lsl;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opLsr: begin
                                        aluFun = cpuDatapathPkg::lsr;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opAnd: begin
                                        aluFun = cpuDatapathPkg::andAB;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opOrr: begin
                                        aluFun = cpuDatapathPkg::orrAB;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opNot: begin
                                        aluFun = cpuDatapathPkg::notA;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opAdd: begin
                                        aluFun = cpuDatapathPkg::add;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opSub: begin
                                        aluFun = cpuDatapathPkg::sub;
                                        regForm = 1'b1;
                                end
                                cpuIsaPkg::opMov: begin
                                        regForm = 1'b1;
                                end
                                default: begin
                                        regForm = 1'b0;         // unknown opcodes do nothing
                                end
                        endcase

                        if (regForm) begin
                                if (dst < cpuIsaPkg::firstGprCode) begin
                                        arf.writeAr = dst >= cpuIsaPkg::arCodeFirst;
                                        arf.writePc = dst < cpuIsaPkg::arCodeFirst;
                                end else begin
                                        gpr.write = 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// ==== source/cpuCtrlIf.sv ====
`default_nettype none

interface gprCtrlIf;
        cpuIsaPkg::gprSelT selA;
        cpuIsaPkg::gprSelT selB;
        cpuIsaPkg::gprSelT writeSel;
        logic write;                            // level strobe, only high in execute

        modport ctrl (
                output selA, selB, writeSel, write
        );

        modport bank (
                input selA, selB, writeSel, write
        );
endinterface

// PC and AR controls, a low select means PC
interface arfCtrlIf;
        logic readSelAr;
        logic addrSelAr;
        logic writeAr;
        logic writePc;
        logic incPc;

        modport ctrl (
                output readSelAr, addrSelAr, writeAr, writePc, incPc
        );

        modport bank (
                input readSelAr, addrSelAr, writeAr, writePc, incPc
        );
endinterface

`default_nettype wire

// ==== source/cpuDatapathPkg.sv ====
`default_nettype none

package cpuDatapathPkg;

        localparam int wordW = 16;
        localparam int byteW = 8;               // memory is byte wide

        typedef logic [wordW-1:0] wordT;
        typedef logic [byteW-1:0] byteT;
        typedef logic [wordW-1:0] addrT;

        typedef enum logic [3:0] {
                passA,
                inc,
                dec,
                notA,
                lsl,
                lsr,
                andAB,
                orrAB,
                add,
                sub
        } aluFunT;

        // what the banks get on their write data
        typedef enum logic [1:0] {
                wbAlu,
                wbMem,
                wbImm
        } wbSrcT;

        typedef enum logic [1:0] {
                fetchLow,
                fetchHigh,
                execute
        } phaseT;

endpackage

`default_nettype wire

// ==== source/cpuIsaPkg.sv ====
`default_nettype none

package cpuIsaPkg;

        localparam int instrW = 16;
        localparam int opW = 6;
        localparam int regCodeW = 3;
        localparam int gprSelW = 2;
        localparam int immW = 8;

        // bit positions of the instruction fields
        localparam int opLsb = 10;
        localparam int dstLsb = 6;              // register form, bit 9 is unused
        localparam int src1Lsb = 3;
        localparam int src2Lsb = 0;
        localparam int rselLsb = 8;             // address form
        localparam int immLsb = 0;

        typedef logic [instrW-1:0] instrT;
        typedef logic [regCodeW-1:0] regCodeT;
        typedef logic [gprSelW-1:0] gprSelT;
        typedef logic [immW-1:0] immT;

        typedef enum logic [opW-1:0] {
                opBra = 6'd0,
                opInc = 6'd5,
                opDec = 6'd6,
                opLsl = 6'd7,
                opLsr = 6'd8,
                opAnd = 6'd12,
                opOrr = 6'd13,
                opNot = 6'd14,
                opLd = 6'd18,
                opSt = 6'd19,
                opImm = 6'd20,
                opAdd = 6'd21,
                opSub = 6'd22,
                opMov = 6'd24
        } opcodeT;

        // codes 0 and 1 are PC, 2 and 3 are AR, 4 to 7 are R1 to R4
        localparam regCodeT arCodeFirst = 3'd2;
        localparam regCodeT firstGprCode = 3'd4;

endpackage

`default_nettype wire

// ==== source/cpuSystem.sv ====
`default_nettype none

module cpuSystem (
        input logic T,
        input logic rstN,
        input cpuDatapathPkg::byteT memRdData,
        output cpuDatapathPkg::addrT memAddr,
        output cpuDatapathPkg::byteT memWrData,
        output logic memWr
);

        gprCtrlIf gprCtrl ();
        arfCtrlIf arfCtrl ();

        cpuDatapathPkg::wordT gprA;
        cpuDatapathPkg::wordT gprB;
        cpuDatapathPkg::wordT arfOperand;
        cpuDatapathPkg::wordT result;                   // write data for both banks
        cpuDatapathPkg::aluFunT aluFun;
        cpuDatapathPkg::wbSrcT wbSrc;
        cpuIsaPkg::immT imm;
        logic aSrcArf;

        controlUnit control0 (
                .T(T),
                .rstN(rstN),
                .memRdData(memRdData),
                .gpr(gprCtrl.ctrl),
                .arf(arfCtrl.ctrl),
                .aluFun(aluFun),
                .aSrcArf(aSrcArf),
                .wbSrc(wbSrc),
                .imm(imm),
                .memWr(memWr)
        );

        generalRegisters gpr0 (
                .T(T),
                .rstN(rstN),
                .ctrl(gprCtrl.bank),
                .writeData(result),
                .outA(gprA),
                .outB(gprB)
        );

        addressRegisters arf0 (
                .T(T),
                .rstN(rstN),
                .ctrl(arfCtrl.bank),
                .writeData(result),
                .operand(arfOperand),
                .memAddr(memAddr)
        );

        aluUnit alu0 (
                .gprA(gprA),
                .gprB(gprB),
                .arfOperand(arfOperand),
                .memRdData(memRdData),
                .imm(imm),
                .aluFun(aluFun),
                .aSrcArf(aSrcArf),
                .wbSrc(wbSrc),
                .result(result)
        );

        assign memWrData = gprA[cpuDatapathPkg::byteW-1:0];

endmodule

`default_nettype wire

// ==== source/generalRegisters.sv ====
`default_nettype none

module generalRegisters (
        input logic T,
        input logic rstN,
        gprCtrlIf.bank ctrl,
        input cpuDatapathPkg::wordT writeData,
        output cpuDatapathPkg::wordT outA,
        output cpuDatapathPkg::wordT outB
);

        localparam int numRegs = 2 ** cpuIsaPkg::gprSelW;

        cpuDatapathPkg::wordT regs [numRegs];   // R1 to R4

        always_ff @(posedge T or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < numRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else if (ctrl.write) begin
                        regs[ctrl.writeSel] <= writeData;
                end
        end

        // both ports read at once, so two-source operations need one cycle
        assign outA = regs[ctrl.selA];
        assign outB = regs[ctrl.selB];

endmodule

`default_nettype wire

// ==== testbench/cpuSystemTb.sv ====
`default_nettype none

module cpuSystemTb;

        localparam int totalInstr = 49;         // instructions executed over all six tests
        localparam int numTests = 6;
        localparam int cycleLimit = 3 * totalInstr + 3 * numTests + 50;
        localparam cpuIsaPkg::regCodeT arCode = 3'd2;

        logic T = 1'b0;
        logic rstN;
        cpuDatapathPkg::byteT memRdData;
        cpuDatapathPkg::addrT memAddr;
        cpuDatapathPkg::byteT memWrData;
        logic memWr;

        cpuDatapathPkg::byteT image [256];      // program image, copied into mem while in reset
        cpuDatapathPkg::byteT mem [256];
        cpuDatapathPkg::addrT storeAddr [$];
        cpuDatapathPkg::byteT storeData [$];
        cpuDatapathPkg::byteT progAddr;
        int numInstr;
        int errors = 0;
        int cycles = 0;

        cpuSystem dut0 (
                .T(T),
                .rstN(rstN),
                .memRdData(memRdData),
                .memAddr(memAddr),
                .memWrData(memWrData),
                .memWr(memWr)
        );

        always #5 T = ~T;

        assign memRdData = mem[memAddr[7:0]];   // asynchronous read, upper address bits ignored

        always @(posedge T) begin
                if (!rstN) begin
                        mem <= image;
                end else if (memWr) begin
                        mem[memAddr[7:0]] <= memWrData;
                end
        end

        // log every store in the middle of its cycle
        always @(negedge T) begin
                if (!rstN) begin
                        storeAddr.delete();
                        storeData.delete();
                end else if (memWr) begin
                        storeAddr.push_back(memAddr);
                        storeData.push_back(memWrData);
                end
        end

        always @(posedge T) begin
                cycles <= cycles + 1;
                if (cycles >= cycleLimit) begin
                        $display("run stopped after %0d cycles, the tests did not finish", cycles);
                        $display("ERRORS FOUND");
                        $finish;
                end
        end

        // opcode in 15:10, bit 9 unused, then destination, source 1, source 2
        function automatic cpuIsaPkg::instrT regInstr(input cpuIsaPkg::opcodeT op,
                        input cpuIsaPkg::regCodeT dst, input cpuIsaPkg::regCodeT src1,
                        input cpuIsaPkg::regCodeT src2);
                return {op, 1'b0, dst, src1, src2};
        endfunction

        function automatic cpuIsaPkg::instrT addrInstr(input cpuIsaPkg::opcodeT op,
                        input cpuIsaPkg::gprSelT rsel, input cpuIsaPkg::immT addr);
                return {op, rsel, addr};
        endfunction

        function automatic cpuIsaPkg::regCodeT gprCode(input cpuIsaPkg::gprSelT n);
                return {1'b1, n};               // R1 to R4 are codes 4 to 7
        endfunction

        function automatic cpuDatapathPkg::byteT randomByte();
                return cpuDatapathPkg::byteT'($urandom);
        endfunction

        task automatic checkAddr(input string name, input cpuDatapathPkg::addrT exp,
                        input cpuDatapathPkg::addrT act);
                if (act !== exp) begin
                        errors++;
                        $display("** Error %s: address expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic checkByte(input string name, input cpuDatapathPkg::byteT exp,
                        input cpuDatapathPkg::byteT act);
                if (act !== exp) begin
                        errors++;
                        $display("** Error %s: data expected %h, actual %h", name, exp, act);
                end
        endtask

        task automatic checkBit(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        errors++;
                        $display("** Error %s: memWr expected %b, actual %b", name, exp, act);
                end
        endtask

        task automatic expectStore(input string name, input int idx,
                        input cpuDatapathPkg::addrT addr, input cpuDatapathPkg::byteT data);
                string tag;
                tag = $sformatf("%s store %0d", name, idx);
                if (idx >= storeAddr.size()) begin
                        errors++;
                        $display("%s: the store never appeared on the bus", tag);
                end else begin
                        checkAddr(tag, addr, storeAddr[idx]);
                        checkByte(tag, data, storeData[idx]);
                end
        endtask

        task automatic expectStoreCount(input string name, input int n);
                if (storeAddr.size() != n) begin
                        errors++;
                        $display("%s: %0d stores seen on the bus where %0d were due",
                                name, storeAddr.size(), n);
                end
        endtask

        task automatic newProgram();
                for (int a = 0; a < 256; a++) begin
                        image[a] = cpuDatapathPkg::byteT'(a * 29 + 7);
                end
                progAddr = 8'h00;
                numInstr = 0;
        endtask

        // instructions sit low byte first
        task automatic emit(input cpuIsaPkg::instrT instr);
                image[progAddr] = instr[7:0];
                image[progAddr + 8'd1] = instr[15:8];
                progAddr = progAddr + 8'd2;
                numInstr++;
        endtask

        task automatic resetCpu();
                @(posedge T);
                rstN <= 1'b0;
                repeat (3) @(posedge T);
                rstN <= 1'b1;
        endtask

        task automatic runProgram();
                resetCpu();
                repeat (3 * numInstr) @(posedge T);
        endtask

        task automatic resetFetch();
                newProgram();
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, 8'h3c));
                resetCpu();
                for (int c = 0; c < 3; c++) begin
                        @(negedge T);
                        if (c < 2) begin
                                checkAddr("resetFetch", cpuDatapathPkg::addrT'(c), memAddr);
                        end
                        checkBit("resetFetch", 1'b0, memWr);
                end
        endtask

        task automatic immMovStore();
                cpuDatapathPkg::byteT vals [4];
                for (int r = 0; r < 4; r++) begin
                        vals[r] = randomByte();
                end
                vals[0] = vals[0] | 8'h80;      // AR stays clear of the program bytes
                newProgram();
                for (int r = 0; r < 4; r++) begin
                        emit(addrInstr(cpuIsaPkg::opImm, cpuIsaPkg::gprSelT'(r), vals[r]));
                end
                emit(regInstr(cpuIsaPkg::opMov, arCode, gprCode(2'd0), 3'd0));
                for (int r = 0; r < 4; r++) begin
                        emit(addrInstr(cpuIsaPkg::opSt, cpuIsaPkg::gprSelT'(r), 8'h00));
                end
                runProgram();
                for (int r = 0; r < 4; r++) begin
                        expectStore("immMovStore", r, cpuDatapathPkg::addrT'(vals[0]), vals[r]);
                end
                expectStoreCount("immMovStore", 4);
        endtask

        task automatic twoSourceOps();
                cpuIsaPkg::opcodeT ops [4];
                cpuDatapathPkg::wordT model [4];
                cpuDatapathPkg::byteT a;
                cpuDatapathPkg::byteT b;
                cpuDatapathPkg::byteT ar;
                ops = '{cpuIsaPkg::opAdd, cpuIsaPkg::opSub, cpuIsaPkg::opAnd, cpuIsaPkg::opOrr};
                a = randomByte();
                b = randomByte();
                ar = randomByte() | 8'h80;
                model[0] = cpuDatapathPkg::wordT'(a) + cpuDatapathPkg::wordT'(b);
                model[1] = cpuDatapathPkg::wordT'(a) - cpuDatapathPkg::wordT'(b);
                model[2] = cpuDatapathPkg::wordT'(a) & cpuDatapathPkg::wordT'(b);
                model[3] = cpuDatapathPkg::wordT'(a) | cpuDatapathPkg::wordT'(b);
                newProgram();
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, a));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd1, b));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd3, ar));
                emit(regInstr(cpuIsaPkg::opMov, arCode, gprCode(2'd3), 3'd0));
                for (int i = 0; i < 4; i++) begin
                        emit(regInstr(ops[i], gprCode(2'd2), gprCode(2'd0), gprCode(2'd1)));
                        emit(addrInstr(cpuIsaPkg::opSt, 2'd2, 8'h00));
                end
                runProgram();
                for (int i = 0; i < 4; i++) begin
                        expectStore("twoSourceOps", i, cpuDatapathPkg::addrT'(ar), model[i][7:0]);
                end
                expectStoreCount("twoSourceOps", 4);
        endtask

        task automatic oneSourceOps();
                cpuDatapathPkg::wordT model [6];
                cpuDatapathPkg::wordT zero;
                cpuDatapathPkg::byteT a;
                cpuDatapathPkg::byteT c;
                cpuDatapathPkg::byteT ar;
                a = randomByte();
                c = randomByte() | 8'h80;       // bit 7 set so LSL carries into bit 8
                ar = randomByte() | 8'h80;
                zero = '0;
                model[0] = cpuDatapathPkg::wordT'(a) + cpuDatapathPkg::wordT'(1);
                model[1] = zero - cpuDatapathPkg::wordT'(1);
                model[2] = ~cpuDatapathPkg::wordT'(a);
                model[3] = cpuDatapathPkg::wordT'(c) << 1;
                model[4] = model[3] >> 1;
                model[5] = cpuDatapathPkg::wordT'(c) >> 1;
                newProgram();
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, a));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd1, 8'h00));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd2, c));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd3, ar));
                emit(regInstr(cpuIsaPkg::opMov, arCode, gprCode(2'd3), 3'd0));
                emit(regInstr(cpuIsaPkg::opInc, gprCode(2'd3), gprCode(2'd0), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                emit(regInstr(cpuIsaPkg::opDec, gprCode(2'd3), gprCode(2'd1), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                emit(regInstr(cpuIsaPkg::opNot, gprCode(2'd3), gprCode(2'd0), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                emit(regInstr(cpuIsaPkg::opLsl, gprCode(2'd3), gprCode(2'd2), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                // shifting back shows that bit 7 went into bit 8
                emit(regInstr(cpuIsaPkg::opLsr, gprCode(2'd3), gprCode(2'd3), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                emit(regInstr(cpuIsaPkg::opLsr, gprCode(2'd3), gprCode(2'd2), 3'd0));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                runProgram();
                for (int i = 0; i < 6; i++) begin
                        expectStore("oneSourceOps", i, cpuDatapathPkg::addrT'(ar), model[i][7:0]);
                end
                expectStoreCount("oneSourceOps", 6);
        endtask

        task automatic loadAdd();
                cpuDatapathPkg::wordT model;
                cpuDatapathPkg::byteT d;
                cpuDatapathPkg::byteT c;
                cpuDatapathPkg::byteT ar;
                d = randomByte();
                c = randomByte();
                ar = randomByte() | 8'h80;
                model = cpuDatapathPkg::wordT'(d) + cpuDatapathPkg::wordT'(c);
                newProgram();
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, ar));
                emit(regInstr(cpuIsaPkg::opMov, arCode, gprCode(2'd0), 3'd0));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd2, c));
                emit(addrInstr(cpuIsaPkg::opLd, 2'd1, 8'h00));
                emit(regInstr(cpuIsaPkg::opAdd, gprCode(2'd3), gprCode(2'd1), gprCode(2'd2)));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd3, 8'h00));
                image[ar] = d;
                runProgram();
                expectStore("loadAdd", 0, cpuDatapathPkg::addrT'(ar), model[7:0]);
                expectStoreCount("loadAdd", 1);
        endtask

        task automatic branchSkip();
                newProgram();
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, 8'h5a));
                emit(addrInstr(cpuIsaPkg::opBra, 2'd0, 8'h0a));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd0, 8'h00));     // skipped
                emit(addrInstr(cpuIsaPkg::opSt, 2'd0, 8'h00));
                emit(addrInstr(cpuIsaPkg::opSt, 2'd0, 8'h00));
                emit(addrInstr(cpuIsaPkg::opImm, 2'd0, 8'ha5));    // branch target at 0x0a
                emit(addrInstr(cpuIsaPkg::opSt, 2'd0, 8'h00));
                resetCpu();
                repeat (6) @(negedge T);
                @(negedge T);
                checkAddr("branchSkip", 16'h000a, memAddr);
                @(negedge T);
                checkAddr("branchSkip", 16'h000b, memAddr);
                repeat (4) @(negedge T);
                @(posedge T);
                expectStore("branchSkip", 0, 16'h0000, 8'ha5);
                expectStoreCount("branchSkip", 1);
        endtask

        initial begin
                rstN = 1'b0;
                void'($urandom(32'hf038fe10));
                resetFetch();
                immMovStore();
                twoSourceOps();
                oneSourceOps();
                loadAdd();
                branchSkip();
                $display("%0d errors after %0d cycles", errors, cycles);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule

`default_nettype wire
